// ==== logic/dm_cache_pkg.sv ====
// shared sizes, address split and array write types of the dm_cache design; compiled before all RTL
package dm_cache_pkg;

  // address and data sizes
  localparam int ADDR_WIDTH     = 16;
  localparam int DATA_WIDTH     = 32;
  localparam int OFFSET_WIDTH   = 4;  // 16-byte line
  localparam int INDEX_WIDTH    = 2;
  localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  // line geometry
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_SEL_WIDTH = 2;
  localparam int NUM_LINES      = 1 << INDEX_WIDTH;
  localparam int BURST_WIDTH    = 3;  // must hold WORDS_PER_LINE

  // sized constants for the controller
  localparam logic [WORD_SEL_WIDTH-1:0] LAST_WORD  = WORD_SEL_WIDTH'(WORDS_PER_LINE - 1);
  localparam logic [BURST_WIDTH-1:0]    LINE_BURST = BURST_WIDTH'(WORDS_PER_LINE);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;

  // byte address split, msb first
  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
  } addr_fields_t;

  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic                 valid;
    logic                 dirty;
  } line_meta_t;

  // one write, seen by both the tag and the data array
  typedef struct packed {
    logic                      en;
    logic [INDEX_WIDTH-1:0]    index;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    word_t                     data;
    logic [TAG_WIDTH-1:0]      tag;
    logic                      valid;
    logic                      dirty;
  } array_wr_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK,
    REFILL
  } fill_state_t;

endpackage

// ==== logic/cache_tag_array.sv ====
// tag, valid and dirty store of the direct-mapped cache; gives both port hits and one line's metadata
module cache_tag_array (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  dm_cache_pkg::addr_fields_t           main_fields_i,
  input  dm_cache_pkg::addr_fields_t           fetch_fields_i,
  input  dm_cache_pkg::array_wr_t              wr_i,
  input  logic [dm_cache_pkg::INDEX_WIDTH-1:0] meta_idx_i,
  output logic                                 main_hit_o,
  output logic                                 fetch_hit_o,
  output dm_cache_pkg::line_meta_t             meta_o
);

  dm_cache_pkg::line_meta_t meta_q [dm_cache_pkg::NUM_LINES];
  dm_cache_pkg::line_meta_t main_meta;
  dm_cache_pkg::line_meta_t fetch_meta;
  dm_cache_pkg::line_meta_t wr_meta;  // current contents of the written line

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < dm_cache_pkg::NUM_LINES; i++) begin
        meta_q[i] <= '0;  // all lines invalid
      end
    end else if (wr_i.en) begin
      meta_q[wr_i.index] <= {wr_i.tag, wr_i.valid, wr_i.dirty};
    end
  end

  assign main_meta  = meta_q[main_fields_i.index];
  assign fetch_meta = meta_q[fetch_fields_i.index];
  assign wr_meta    = meta_q[wr_i.index];

  assign main_hit_o  = main_meta.valid && (main_meta.tag == main_fields_i.tag);
  assign fetch_hit_o = fetch_meta.valid && (fetch_meta.tag == fetch_fields_i.tag);

  assign meta_o = meta_q[meta_idx_i];  // victim info for the controller

  // a dirty line of another tag is only replaced after its write-back
  a_no_dirty_overwrite: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_i.en |-> !(wr_meta.valid && wr_meta.dirty && (wr_meta.tag != wr_i.tag))
  );

endmodule

// ==== logic/cache_data_array.sv ====
// word storage of the cache; two front read ports, a victim read port and one write port
module cache_data_array (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  dm_cache_pkg::addr_fields_t              main_addr_i,
  input  dm_cache_pkg::addr_fields_t              fetch_addr_i,
  input  dm_cache_pkg::array_wr_t                 wr_i,
  input  logic [dm_cache_pkg::INDEX_WIDTH-1:0]    victim_idx_i,
  input  logic [dm_cache_pkg::WORD_SEL_WIDTH-1:0] victim_word_i,
  output dm_cache_pkg::word_t                     main_rdata_o,
  output dm_cache_pkg::word_t                     fetch_rdata_o,
  output dm_cache_pkg::word_t                     victim_data_o
);

  dm_cache_pkg::word_t mem_q [dm_cache_pkg::NUM_LINES][dm_cache_pkg::WORDS_PER_LINE];

  logic [dm_cache_pkg::WORD_SEL_WIDTH-1:0] main_word;
  logic [dm_cache_pkg::WORD_SEL_WIDTH-1:0] fetch_word;

  // word select is the upper part of the byte offset
  assign main_word  = main_addr_i.offset[dm_cache_pkg::OFFSET_WIDTH-1 -: dm_cache_pkg::WORD_SEL_WIDTH];
  assign fetch_word = fetch_addr_i.offset[dm_cache_pkg::OFFSET_WIDTH-1 -: dm_cache_pkg::WORD_SEL_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_i.en) begin
      mem_q[wr_i.index][wr_i.word_sel] <= wr_i.data;
    end
  end

  assign main_rdata_o  = mem_q[main_addr_i.index][main_word];
  assign fetch_rdata_o = mem_q[fetch_addr_i.index][fetch_word];
  assign victim_data_o = mem_q[victim_idx_i][victim_word_i];  // write-back source

endmodule

// ==== logic/cache_ctrl.sv ====
// miss handling of the cache; write-back and refill FSM, memory burst driver and array write mux
module cache_ctrl (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  dm_cache_pkg::addr_fields_t              main_fields_i,
  input  dm_cache_pkg::addr_fields_t              fetch_fields_i,
  input  logic                                    main_read_i,
  input  logic                                    main_write_i,
  input  logic                                    fetch_read_i,
  input  dm_cache_pkg::word_t                     main_wdata_i,
  input  logic                                    main_hit_i,
  input  logic                                    fetch_hit_i,
  input  dm_cache_pkg::line_meta_t                meta_i,
  input  dm_cache_pkg::word_t                     victim_data_i,
  output logic [dm_cache_pkg::INDEX_WIDTH-1:0]    meta_idx_o,
  output logic [dm_cache_pkg::WORD_SEL_WIDTH-1:0] victim_word_o,
  output dm_cache_pkg::array_wr_t                 wr_o,
  output logic                                    main_wait_o,
  output logic                                    fetch_wait_o,
  output dm_cache_pkg::addr_t                     mem_addr_o,
  output logic [dm_cache_pkg::BURST_WIDTH-1:0]    mem_burstcount_o,
  output logic                                    mem_read_o,
  output logic                                    mem_write_o,
  output dm_cache_pkg::word_t                     mem_wdata_o,
  input  dm_cache_pkg::word_t                     mem_rdata_i,
  input  logic                                    mem_wait_i,
  input  logic                                    mem_rdata_valid_i
);

  dm_cache_pkg::fill_state_t state_q;
  logic [dm_cache_pkg::WORD_SEL_WIDTH-1:0] word_cnt_q;
  dm_cache_pkg::addr_fields_t miss_q;

  dm_cache_pkg::addr_fields_t miss_sel;
  dm_cache_pkg::addr_fields_t miss_fields;
  dm_cache_pkg::addr_t victim_line_addr;
  dm_cache_pkg::addr_t fill_line_addr;
  logic [dm_cache_pkg::WORD_SEL_WIDTH-1:0] main_word;

  logic main_req;
  logic main_miss;
  logic fetch_miss;
  logic main_wr_hit;
  logic start_miss;
  logic victim_dirty;
  logic last_word;
  logic wb_done;

  assign main_req    = main_read_i || main_write_i;
  assign main_miss   = main_req && !main_hit_i;
  assign fetch_miss  = fetch_read_i && !fetch_hit_i;
  assign main_wr_hit = main_write_i && main_hit_i;

  // main port first; a fetch miss also yields to a write hit in the same cycle
  assign start_miss = (state_q == dm_cache_pkg::IDLE) &&
                      (main_miss || (fetch_miss && !main_wr_hit));

  assign miss_sel    = main_miss ? main_fields_i : fetch_fields_i;
  assign miss_fields = (state_q == dm_cache_pkg::IDLE) ? miss_sel : miss_q;

  assign victim_dirty = meta_i.valid && meta_i.dirty;
  assign last_word    = (word_cnt_q == dm_cache_pkg::LAST_WORD);
  assign wb_done      = (state_q == dm_cache_pkg::WRITE_BACK) && !mem_wait_i && last_word;

  // line-aligned burst addresses
  assign victim_line_addr = {meta_i.tag, miss_fields.index, {dm_cache_pkg::OFFSET_WIDTH{1'b0}}};
  assign fill_line_addr   = {miss_fields.tag, miss_fields.index,
                             {dm_cache_pkg::OFFSET_WIDTH{1'b0}}};

  assign main_word = main_fields_i.offset[dm_cache_pkg::OFFSET_WIDTH-1 -: dm_cache_pkg::WORD_SEL_WIDTH];

  assign meta_idx_o       = miss_fields.index;
  assign victim_word_o    = word_cnt_q;
  assign mem_wdata_o      = victim_data_i;
  assign mem_burstcount_o = dm_cache_pkg::LINE_BURST;  // words, not bytes

  // writes wait outside IDLE since the array write port belongs to the refill
  assign main_wait_o  = main_miss || (main_write_i && (state_q != dm_cache_pkg::IDLE));
  assign fetch_wait_o = fetch_miss;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= dm_cache_pkg::IDLE;
      word_cnt_q  <= '0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
    end else begin
      case (state_q)
        dm_cache_pkg::IDLE: begin
          word_cnt_q <= '0;
          if (start_miss) begin
            if (victim_dirty) begin
              state_q     <= dm_cache_pkg::WRITE_BACK;
              mem_write_o <= 1'b1;
            end else begin
              state_q    <= dm_cache_pkg::REFILL;
              mem_read_o <= 1'b1;
            end
          end
        end
        dm_cache_pkg::WRITE_BACK: begin
          if (!mem_wait_i) begin  // word accepted
            if (last_word) begin
              state_q     <= dm_cache_pkg::REFILL;
              word_cnt_q  <= '0;
              mem_write_o <= 1'b0;
              mem_read_o  <= 1'b1;
            end else begin
              word_cnt_q <= word_cnt_q + 1'b1;
            end
          end
        end
        dm_cache_pkg::REFILL: begin
          if (mem_read_o && !mem_wait_i) begin
            mem_read_o <= 1'b0;  // burst accepted
          end
          if (mem_rdata_valid_i) begin
            if (last_word) begin
              state_q    <= dm_cache_pkg::IDLE;
              word_cnt_q <= '0;
            end else begin
              word_cnt_q <= word_cnt_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= dm_cache_pkg::IDLE;
        end
      endcase
    end
  end

  // miss address and burst address
  always_ff @(posedge clk) begin
    if (start_miss) begin
      miss_q     <= miss_sel;
      mem_addr_o <= victim_dirty ? victim_line_addr : fill_line_addr;
    end else if (wb_done) begin
      mem_addr_o <= fill_line_addr;
    end
  end

  always_comb begin
    wr_o = '0;
    case (state_q)
      dm_cache_pkg::IDLE: begin
        wr_o.en       = main_wr_hit;
        wr_o.index    = main_fields_i.index;
        wr_o.word_sel = main_word;
        wr_o.data     = main_wdata_i;
        wr_o.tag      = main_fields_i.tag;
        wr_o.valid    = 1'b1;
        wr_o.dirty    = 1'b1;
      end
      dm_cache_pkg::WRITE_BACK: begin
        // rewrite the last victim word unchanged so the line reads clean
        wr_o.en       = wb_done;
        wr_o.index    = miss_q.index;
        wr_o.word_sel = word_cnt_q;
        wr_o.data     = victim_data_i;
        wr_o.tag      = meta_i.tag;
        wr_o.valid    = 1'b1;
        wr_o.dirty    = 1'b0;
      end
      dm_cache_pkg::REFILL: begin
        wr_o.en       = mem_rdata_valid_i;
        wr_o.index    = miss_q.index;
        wr_o.word_sel = word_cnt_q;
        wr_o.data     = mem_rdata_i;
        wr_o.tag      = miss_q.tag;
        wr_o.valid    = last_word;  // line usable after final word
        wr_o.dirty    = 1'b0;
      end
      default: begin
        wr_o = '0;
      end
    endcase
  end

  a_mem_rw_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(mem_read_o && mem_write_o)
  );

  // read data from memory only while a refill is in flight
  a_rdata_in_refill: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_rdata_valid_i |-> (state_q == dm_cache_pkg::REFILL)
  );

endmodule

// ==== logic/dm_cache_top.sv ====
// top of the direct-mapped write-back cache; main and fetch front ports plus one burst memory port
module dm_cache_top (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // main port
  input  dm_cache_pkg::addr_t                  main_addr_i,
  input  logic                                 main_read_i,
  input  logic                                 main_write_i,
  input  dm_cache_pkg::word_t                  main_wdata_i,
  output dm_cache_pkg::word_t                  main_rdata_o,
  output logic                                 main_wait_o,

  // read-only fetch port
  input  dm_cache_pkg::addr_t                  fetch_addr_i,
  input  logic                                 fetch_read_i,
  output dm_cache_pkg::word_t                  fetch_rdata_o,
  output logic                                 fetch_wait_o,

  // burst memory port
  output dm_cache_pkg::addr_t                  mem_addr_o,
  output logic [dm_cache_pkg::BURST_WIDTH-1:0] mem_burstcount_o,
  output logic                                 mem_read_o,
  output logic                                 mem_write_o,
  output dm_cache_pkg::word_t                  mem_wdata_o,
  input  dm_cache_pkg::word_t                  mem_rdata_i,
  input  logic                                 mem_wait_i,
  input  logic                                 mem_rdata_valid_i
);

  dm_cache_pkg::addr_fields_t main_fields;
  dm_cache_pkg::addr_fields_t fetch_fields;
  dm_cache_pkg::array_wr_t    array_wr;
  dm_cache_pkg::line_meta_t   meta;
  dm_cache_pkg::word_t        victim_data;

  logic [dm_cache_pkg::INDEX_WIDTH-1:0]    meta_idx;
  logic [dm_cache_pkg::WORD_SEL_WIDTH-1:0] victim_word;
  logic                                    main_hit;
  logic                                    fetch_hit;

  assign main_fields  = dm_cache_pkg::addr_fields_t'(main_addr_i);
  assign fetch_fields = dm_cache_pkg::addr_fields_t'(fetch_addr_i);

  cache_tag_array u_tag_array (
    .clk            (clk),
    .rst_n          (rst_n),
    .main_fields_i  (main_fields),
    .fetch_fields_i (fetch_fields),
    .wr_i           (array_wr),
    .meta_idx_i     (meta_idx),
    .main_hit_o     (main_hit),
    .fetch_hit_o    (fetch_hit),
    .meta_o         (meta)
  );

  cache_data_array u_data_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .main_addr_i   (main_fields),
    .fetch_addr_i  (fetch_fields),
    .wr_i          (array_wr),
    .victim_idx_i  (meta_idx),  // same line as the metadata lookup
    .victim_word_i (victim_word),
    .main_rdata_o  (main_rdata_o),
    .fetch_rdata_o (fetch_rdata_o),
    .victim_data_o (victim_data)
  );

  cache_ctrl u_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .main_fields_i     (main_fields),
    .fetch_fields_i    (fetch_fields),
    .main_read_i       (main_read_i),
    .main_write_i      (main_write_i),
    .fetch_read_i      (fetch_read_i),
    .main_wdata_i      (main_wdata_i),
    .main_hit_i        (main_hit),
    .fetch_hit_i       (fetch_hit),
    .meta_i            (meta),
    .victim_data_i     (victim_data),
    .meta_idx_o        (meta_idx),
    .victim_word_o     (victim_word),
    .wr_o              (array_wr),
    .main_wait_o       (main_wait_o),
    .fetch_wait_o      (fetch_wait_o),
    .mem_addr_o        (mem_addr_o),
    .mem_burstcount_o  (mem_burstcount_o),
    .mem_read_o        (mem_read_o),
    .mem_write_o       (mem_write_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_rdata_i       (mem_rdata_i),
    .mem_wait_i        (mem_wait_i),
    .mem_rdata_valid_i (mem_rdata_valid_i)
  );

endmodule

// ==== tb/avalon_mem_model.sv ====
// burst memory behind the cache in the testbench; random wait and read gaps, logs each written word
module avalon_mem_model (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  dm_cache_pkg::addr_t                  mem_addr_i,
  input  logic [dm_cache_pkg::BURST_WIDTH-1:0] mem_burstcount_i,
  input  logic                                 mem_read_i,
  input  logic                                 mem_write_i,
  input  dm_cache_pkg::word_t                  mem_wdata_i,
  output dm_cache_pkg::word_t                  mem_rdata_o,
  output logic                                 mem_wait_o,
  output logic                                 mem_rdata_valid_o,
  output logic                                 log_valid_o,
  output dm_cache_pkg::addr_t                  log_addr_o,
  output dm_cache_pkg::word_t                  log_data_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 1 << (dm_cache_pkg::ADDR_WIDTH - 2);

  dm_cache_pkg::word_t mem_q [MEM_WORDS];
  dm_cache_pkg::addr_t rd_addr_q;
  dm_cache_pkg::addr_t wr_addr;
  int unsigned         rd_left_q;
  int unsigned         wr_cnt_q;

  // initial contents, mixes every address bit
  function automatic dm_cache_pkg::word_t addr_hash(dm_cache_pkg::addr_t addr);
    dm_cache_pkg::word_t h;
    h = {addr, ~addr} ^ (32'h9e37_79b1 * {16'h0000, addr});
    return h;
  endfunction

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = addr_hash(dm_cache_pkg::addr_t'(i << 2));
    end
  end

  assign wr_addr = mem_addr_i + dm_cache_pkg::addr_t'(wr_cnt_q << 2);  // beat within burst

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_wait_o        <= 1'b0;
      mem_rdata_valid_o <= 1'b0;
      mem_rdata_o       <= '0;
      log_valid_o       <= 1'b0;
      log_addr_o        <= '0;
      log_data_o        <= '0;
      rd_addr_q         <= '0;
      rd_left_q         <= 0;
      wr_cnt_q          <= 0;
    end else begin
      mem_wait_o        <= ($urandom % 3) == 0;  // back-pressure about a third of cycles
      mem_rdata_valid_o <= 1'b0;
      log_valid_o       <= 1'b0;
      if (mem_write_i && !mem_wait_o) begin
        mem_q[wr_addr >> 2] <= mem_wdata_i;
        log_valid_o         <= 1'b1;
        log_addr_o          <= wr_addr;
        log_data_o          <= mem_wdata_i;
        wr_cnt_q            <= (wr_cnt_q + 1 == mem_burstcount_i) ? 0 : wr_cnt_q + 1;
      end
      if (mem_read_i && !mem_wait_o) begin
        rd_addr_q <= mem_addr_i;  // burst accepted
        rd_left_q <= mem_burstcount_i;
      end else if (rd_left_q != 0 && ($urandom % 4) != 0) begin
        mem_rdata_valid_o <= 1'b1;
        mem_rdata_o       <= mem_q[rd_addr_q >> 2];
        rd_addr_q         <= rd_addr_q + 4;
        rd_left_q         <= rd_left_q - 1;
      end
    end
  end

endmodule

// ==== tb/dm_cache_tb.sv ====
// testbench of the dm_cache design; directed and random traffic on both ports against a flat model
module dm_cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     CLK_PERIOD    = 40;
  localparam int     DRIVE_DELAY   = 2;
  localparam int     RESET_CYCLES  = 10;
  localparam int     SEED          = 30188;
  localparam int     RAND_OPS      = 370;
  localparam int     MAX_OPS       = 400;
  localparam int     CYCLES_PER_OP = 60;
  localparam longint WATCHDOG_NS   = longint'(MAX_OPS) * CYCLES_PER_OP * CLK_PERIOD;
  localparam int     MEM_WORDS     = 1 << (dm_cache_pkg::ADDR_WIDTH - 2);
  localparam logic [dm_cache_pkg::BURST_WIDTH-1:0] BURST_EXPECT = 4;  // words per line

  logic clk;
  logic rst_n;
  dm_cache_pkg::addr_t main_addr;
  logic main_read;
  logic main_write;
  dm_cache_pkg::word_t main_wdata;
  dm_cache_pkg::word_t main_rdata;
  logic main_wait;
  dm_cache_pkg::addr_t fetch_addr;
  logic fetch_read;
  dm_cache_pkg::word_t fetch_rdata;
  logic fetch_wait;
  dm_cache_pkg::addr_t mem_addr;
  logic [dm_cache_pkg::BURST_WIDTH-1:0] mem_burstcount;
  logic mem_read;
  logic mem_write;
  dm_cache_pkg::word_t mem_wdata;
  dm_cache_pkg::word_t mem_rdata;
  logic mem_wait;
  logic mem_rdata_valid;
  logic log_valid;
  dm_cache_pkg::addr_t log_addr;
  dm_cache_pkg::word_t log_data;

  dm_cache_pkg::word_t model_mem [MEM_WORDS];  // reference contents of the whole space
  logic main_busy;
  logic main_is_wr;
  dm_cache_pkg::addr_t main_op_addr;
  dm_cache_pkg::word_t main_op_data;
  logic fetch_busy;
  dm_cache_pkg::addr_t fetch_op_addr;
  dm_cache_pkg::addr_t last_wb_addr;
  int unsigned rd_bursts;
  int unsigned wb_words;
  int unsigned wb_beat;
  string test_name;

  dm_cache_top dm_cache_top_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .main_addr_i       (main_addr),
    .main_read_i       (main_read),
    .main_write_i      (main_write),
    .main_wdata_i      (main_wdata),
    .main_rdata_o      (main_rdata),
    .main_wait_o       (main_wait),
    .fetch_addr_i      (fetch_addr),
    .fetch_read_i      (fetch_read),
    .fetch_rdata_o     (fetch_rdata),
    .fetch_wait_o      (fetch_wait),
    .mem_addr_o        (mem_addr),
    .mem_burstcount_o  (mem_burstcount),
    .mem_read_o        (mem_read),
    .mem_write_o       (mem_write),
    .mem_wdata_o       (mem_wdata),
    .mem_rdata_i       (mem_rdata),
    .mem_wait_i        (mem_wait),
    .mem_rdata_valid_i (mem_rdata_valid)
  );

  avalon_mem_model u_mem (
    .clk               (clk),
    .rst_n             (rst_n),
    .mem_addr_i        (mem_addr),
    .mem_burstcount_i  (mem_burstcount),
    .mem_read_i        (mem_read),
    .mem_write_i       (mem_write),
    .mem_wdata_i       (mem_wdata),
    .mem_rdata_o       (mem_rdata),
    .mem_wait_o        (mem_wait),
    .mem_rdata_valid_o (mem_rdata_valid),
    .log_valid_o       (log_valid),
    .log_addr_o        (log_addr),
    .log_data_o        (log_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string what, dm_cache_pkg::word_t exp, dm_cache_pkg::word_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(string what, dm_cache_pkg::addr_t exp, dm_cache_pkg::addr_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_count(string what, logic [dm_cache_pkg::BURST_WIDTH-1:0] exp,
                             logic [dm_cache_pkg::BURST_WIDTH-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  function automatic dm_cache_pkg::addr_t line_base(dm_cache_pkg::addr_t addr);
    return addr & ~dm_cache_pkg::addr_t'((1 << dm_cache_pkg::OFFSET_WIDTH) - 1);
  endfunction

  // byte offset within the line, zero for an aligned burst
  function automatic dm_cache_pkg::addr_t line_offset(dm_cache_pkg::addr_t addr);
    return addr & dm_cache_pkg::addr_t'((1 << dm_cache_pkg::OFFSET_WIDTH) - 1);
  endfunction

  // 32 words over three tags, all four indexes
  function automatic dm_cache_pkg::addr_t random_addr();
    logic [9:0] tags [3];
    int unsigned id;
    tags[0] = 10'h005;
    tags[1] = 10'h0a2;
    tags[2] = 10'h3f1;
    id = $urandom % 32;
    return {tags[id % 3], id[3:0], 2'b00};
  endfunction

  task automatic drive_ports();
    main_addr  = main_op_addr;
    main_read  = main_busy && !main_is_wr;
    main_write = main_busy && main_is_wr;
    main_wdata = main_op_data;
    fetch_addr = fetch_op_addr;
    fetch_read = fetch_busy;
  endtask

  task automatic watch_memory_port();
    if (mem_read && !mem_wait) begin
      check_addr("read burst offset", '0, line_offset(mem_addr));
      check_count("read burst count", BURST_EXPECT, mem_burstcount);
      rd_bursts++;
    end
    if (mem_write && !mem_wait) begin
      if (wb_beat == 0) begin
        check_addr("write burst offset", '0, line_offset(mem_addr));
        check_count("write burst count", BURST_EXPECT, mem_burstcount);
        last_wb_addr = mem_addr;
      end
      wb_beat = (wb_beat + 1) % dm_cache_pkg::WORDS_PER_LINE;
    end
    if (log_valid) begin
      check_word("write-back data", model_mem[log_addr >> 2], log_data);
      wb_words++;
    end
  endtask

  // one clock: sample at the edge, then drive after a short delay
  task automatic step();
    logic main_done;
    logic fetch_done;
    @(posedge clk);
    watch_memory_port();
    main_done  = main_busy && !main_wait;
    fetch_done = fetch_busy && !fetch_wait;
    if (fetch_done) begin
      check_word("fetch read", model_mem[fetch_op_addr >> 2], fetch_rdata);
      fetch_busy = 1'b0;
    end
    if (main_done) begin
      if (main_is_wr) begin
        model_mem[main_op_addr >> 2] = main_op_data;  // lands at this edge
      end else begin
        check_word("main read", model_mem[main_op_addr >> 2], main_rdata);
      end
      main_busy = 1'b0;
    end
    #DRIVE_DELAY;
    drive_ports();
  endtask

  task automatic start_main(logic is_wr, dm_cache_pkg::addr_t addr, dm_cache_pkg::word_t data);
    main_busy    = 1'b1;
    main_is_wr   = is_wr;
    main_op_addr = addr;
    main_op_data = data;
    drive_ports();
  endtask

  task automatic start_fetch(dm_cache_pkg::addr_t addr);
    fetch_busy    = 1'b1;
    fetch_op_addr = addr;
    drive_ports();
  endtask

  task automatic main_access(logic is_wr, dm_cache_pkg::addr_t addr, dm_cache_pkg::word_t data);
    start_main(is_wr, addr, data);
    while (main_busy) step();
  endtask

  task automatic fetch_access(dm_cache_pkg::addr_t addr);
    start_fetch(addr);
    while (fetch_busy) step();
  endtask

  task automatic run_random_mix();
    int unsigned issued;
    logic is_wr;
    dm_cache_pkg::addr_t addr;
    dm_cache_pkg::word_t data;
    test_name = "random_mix";
    issued = 0;
    while (issued < RAND_OPS || main_busy || fetch_busy) begin
      if (!main_busy && issued < RAND_OPS && ($urandom % 4) != 0) begin
        is_wr = ($urandom % 5) < 2;
        addr  = random_addr();
        data  = $urandom;
        start_main(is_wr, addr, data);
        issued++;
      end
      if (!fetch_busy && issued < RAND_OPS && ($urandom % 3) != 0) begin
        start_fetch(random_addr());
        issued++;
      end
      step();
    end
  endtask

  initial begin
    dm_cache_pkg::fill_state_t hang_state;
    #(WATCHDOG_NS);
    hang_state = dm_cache_top_i.u_ctrl.state_q;
    $display("watchdog expired in %s, controller in state %s", test_name, hang_state.name());
    $display("TEST FAILED");
    $fatal(1, "simulation hung");
  end

  initial begin
    int unsigned wb_before;
    int unsigned rd_before;
    void'($urandom(SEED));
    rst_n        = 1'b0;
    main_busy    = 1'b0;
    main_is_wr   = 1'b0;
    main_op_addr = '0;
    main_op_data = '0;
    fetch_busy   = 1'b0;
    fetch_op_addr = '0;
    last_wb_addr = '0;
    rd_bursts    = 0;
    wb_words     = 0;
    wb_beat      = 0;
    test_name    = "reset";
    drive_ports();
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = u_mem.addr_hash(dm_cache_pkg::addr_t'(i << 2));
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    if (mem_read || mem_write) begin
      fail_run("memory read or write strobe is high after reset");
    end
    main_access(1'b0, 16'h0040, '0);
    fetch_access(16'h0104);

    test_name = "write_read";
    main_access(1'b1, 16'h0044, $urandom);  // line not resident any more
    main_access(1'b0, 16'h0044, '0);
    fetch_access(16'h0044);
    main_access(1'b1, 16'h004c, $urandom);  // same line, now a write hit
    main_access(1'b0, 16'h004c, '0);
    fetch_access(16'h004c);

    test_name = "dirty_evict";
    wb_before = wb_words;
    main_access(1'b1, 16'h0024, $urandom);
    main_access(1'b0, 16'h0424, '0);  // same index, other tag
    if (wb_words - wb_before != dm_cache_pkg::WORDS_PER_LINE) begin
      fail_run("dirty eviction did not write back exactly one line");
    end
    check_addr("victim line address", line_base(16'h0024), last_wb_addr);

    test_name = "clean_evict";
    wb_before = wb_words;
    rd_before = rd_bursts;
    fetch_access(16'h0824);
    if (wb_words != wb_before || rd_bursts != rd_before + 1) begin
      fail_run("clean eviction did not produce a single read burst");
    end

    run_random_mix();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== dm_cache.f ====
logic/dm_cache_pkg.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache_ctrl.sv
logic/dm_cache_top.sv
tb/avalon_mem_model.sv
tb/dm_cache_tb.sv

// ==== Bender.yml ====
package:
  name: dm_cache

sources:
  - logic/dm_cache_pkg.sv
  - logic/cache_tag_array.sv
  - logic/cache_data_array.sv
  - logic/cache_ctrl.sv
  - logic/dm_cache_top.sv
  - target: simulation
    files:
      - tb/avalon_mem_model.sv
      - tb/dm_cache_tb.sv
